/* hw/cop_pkg.sv */
// ====================
// Fixed custom-0 encoding. Only packed arithmetic and move classes exist,
// every other class code decodes as illegal
// ====================
`default_nettype none

package cop_pkg;

    // Major opcode, custom-0
    localparam logic [6:0] COP_OPCODE = 7'b0001011;

    // Field positions in the instruction word
    localparam int COP_F_CLASS_LSB    = 28; // 4 bits
    localparam int COP_F_SUBCLASS_LSB = 25; // 3 bits
    localparam int COP_F_PW_LSB       = 22; // 3 bits
    localparam int COP_F_CRS2_LSB     = 18; // Shared with shift amount
    localparam int COP_F_CRS1_LSB     = 14;
    localparam int COP_F_CRD_LSB      = 8;
    localparam int COP_F_RD_LSB       = 7;  // 5 bits, overlaps crd

    // Supported classes
    localparam logic [3:0] COP_ICLASS_PACKED_ARITH = 4'h1;
    localparam logic [3:0] COP_ICLASS_MOVE         = 4'h5;

    // Packed arithmetic subclasses
    localparam logic [2:0] COP_SCLASS_PADD   = 3'd0;
    localparam logic [2:0] COP_SCLASS_PSUB   = 3'd1;
    localparam logic [2:0] COP_SCLASS_PSLL_I = 3'd2;
    localparam logic [2:0] COP_SCLASS_PSRL_I = 3'd3;

    // Move subclasses
    localparam logic [2:0] COP_SCLASS_GPR2XCR = 3'd0; // crd <- rs1
    localparam logic [2:0] COP_SCLASS_XCR2GPR = 3'd1; // rd <- crs1
    localparam logic [2:0] COP_SCLASS_WMCCR   = 3'd2; // mccr <- rs1[5:0]
    localparam logic [2:0] COP_SCLASS_RMCCR   = 3'd3; // rd <- mccr

    // Pack widths, 5 to 7 illegal
    localparam logic [2:0] COP_PW_32 = 3'd0;
    localparam logic [2:0] COP_PW_16 = 3'd1;
    localparam logic [2:0] COP_PW_8  = 3'd2;
    localparam logic [2:0] COP_PW_4  = 3'd3;
    localparam logic [2:0] COP_PW_2  = 3'd4;

    // MCCR enable bits
    localparam int COP_MCCR_W   = 6;
    localparam int COP_MCCR_PA  = 0;
    localparam int COP_MCCR_P32 = 1;
    localparam int COP_MCCR_P16 = 2;
    localparam int COP_MCCR_P8  = 3;
    localparam int COP_MCCR_P4  = 4;
    localparam int COP_MCCR_P2  = 5;
    localparam logic [COP_MCCR_W-1:0] COP_MCCR_RESET = '1; // Everything on

    // Sequencer states
    localparam logic [1:0] COP_ST_IDLE = 2'd0;
    localparam logic [1:0] COP_ST_EXEC = 2'd1;
    localparam logic [1:0] COP_ST_ACK  = 2'd2;

    // One CPR word seen as lanes
    typedef union packed {
        logic [31:0]       w;
        logic [1:0][15:0]  h;
        logic [3:0][7:0]   b;
        logic [7:0][3:0]   n;
        logic [15:0][1:0]  c;
    } cop_word_u;

endpackage

`default_nettype wire

/* hw/cop_idecode.sv */
// ====================
// Purely combinational. Write enables are ungated here and must be
// qualified by the commit pulse before reaching any state
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_idecode (
    input  wire logic [31:0] id_encoded_i,  // Captured instruction
    input  wire logic [5:0]  mccr_i,        // Feature enables
    output logic             id_exception_o,
    output logic [3:0]       id_class_o,
    output logic [2:0]       id_subclass_o,
    output logic [2:0]       id_pw_o,
    output logic [3:0]       id_crs1_o,
    output logic [3:0]       id_crs2_o,
    output logic [3:0]       id_crd_o,
    output logic [4:0]       id_rd_o,
    output logic [3:0]       id_shamt_o,
    output logic             id_cpr_wen_o,
    output logic             id_gpr_wen_o,
    output logic             id_mccr_wen_o
);

    logic       opcode_ok;
    logic       class_pa;
    logic       class_mv;
    logic       bad_subclass;
    logic       bad_pack_width;
    logic       pw_enabled;
    logic       legal;

    // Field extraction
    assign id_class_o    = id_encoded_i[cop_pkg::COP_F_CLASS_LSB +: 4];
    assign id_subclass_o = id_encoded_i[cop_pkg::COP_F_SUBCLASS_LSB +: 3];
    assign id_pw_o       = id_encoded_i[cop_pkg::COP_F_PW_LSB +: 3];
    assign id_crs1_o     = id_encoded_i[cop_pkg::COP_F_CRS1_LSB +: 4];
    assign id_crs2_o     = id_encoded_i[cop_pkg::COP_F_CRS2_LSB +: 4];
    assign id_shamt_o    = id_encoded_i[cop_pkg::COP_F_CRS2_LSB +: 4];
    assign id_crd_o      = id_encoded_i[cop_pkg::COP_F_CRD_LSB +: 4];
    assign id_rd_o       = id_encoded_i[cop_pkg::COP_F_RD_LSB +: 5];

    assign opcode_ok = id_encoded_i[6:0] == cop_pkg::COP_OPCODE;
    assign class_pa  = id_class_o == cop_pkg::COP_ICLASS_PACKED_ARITH;
    assign class_mv  = id_class_o == cop_pkg::COP_ICLASS_MOVE;

    // Both classes use subclasses 0..3 only
    assign bad_subclass =
        (class_pa && id_subclass_o > cop_pkg::COP_SCLASS_PSRL_I) ||
        (class_mv && id_subclass_o > cop_pkg::COP_SCLASS_RMCCR);

    assign bad_pack_width = class_pa && id_pw_o > cop_pkg::COP_PW_2;

    // Per-width feature switch
    always_comb begin
        case (id_pw_o)
            cop_pkg::COP_PW_32: pw_enabled = mccr_i[cop_pkg::COP_MCCR_P32];
            cop_pkg::COP_PW_16: pw_enabled = mccr_i[cop_pkg::COP_MCCR_P16];
            cop_pkg::COP_PW_8:  pw_enabled = mccr_i[cop_pkg::COP_MCCR_P8];
            cop_pkg::COP_PW_4:  pw_enabled = mccr_i[cop_pkg::COP_MCCR_P4];
            cop_pkg::COP_PW_2:  pw_enabled = mccr_i[cop_pkg::COP_MCCR_P2];
            default:            pw_enabled = 1'b0;
        endcase
    end

    assign id_exception_o =
        !opcode_ok                                       ||
        !(class_pa || class_mv)                          ||
        bad_subclass                                     ||
        bad_pack_width                                   ||
        (class_pa && !mccr_i[cop_pkg::COP_MCCR_PA])      ||
        (class_pa && !pw_enabled);

    assign legal = !id_exception_o;

    assign id_cpr_wen_o  = legal && (class_pa ||
                           (class_mv && id_subclass_o == cop_pkg::COP_SCLASS_GPR2XCR));
    assign id_gpr_wen_o  = legal && class_mv &&
                           (id_subclass_o == cop_pkg::COP_SCLASS_XCR2GPR ||
                            id_subclass_o == cop_pkg::COP_SCLASS_RMCCR);
    assign id_mccr_wen_o = legal && class_mv && id_subclass_o == cop_pkg::COP_SCLASS_WMCCR;

endmodule

`default_nettype wire

/* hw/cop_mccr.sv */
// ====================
// Feature enables, all on after reset
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_mccr (
    input  wire logic       g_clk_i,
    input  wire logic       arst_n_i,
    input  wire logic       wen_i,    // Already gated by commit
    input  wire logic [5:0] wdata_i,
    output logic [5:0]      mccr_o
);

    logic [cop_pkg::COP_MCCR_W-1:0] mccr_q;

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mccr_q <= cop_pkg::COP_MCCR_RESET;
        end else if (wen_i) begin
            mccr_q <= wdata_i;
        end
    end

    assign mccr_o = mccr_q;

endmodule

`default_nettype wire

/* hw/cop_regfile.sv */
// ====================
// 16 CPRs, zero after reset. Reads are asynchronous
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_regfile (
    input  wire logic              g_clk_i,
    input  wire logic              arst_n_i,
    input  wire logic [3:0]        raddr1_i,
    input  wire logic [3:0]        raddr2_i,
    input  wire logic              wen_i,
    input  wire logic [3:0]        waddr_i,
    input  wire cop_pkg::cop_word_u wdata_i,
    output cop_pkg::cop_word_u     rdata1_o,
    output cop_pkg::cop_word_u     rdata2_o
);

    cop_pkg::cop_word_u cpr_q [16];

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                cpr_q[i] <= '0;
            end
        end else if (wen_i) begin
            cpr_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = cpr_q[raddr1_i];
    assign rdata2_o = cpr_q[raddr2_i]; // Second operand for padd/psub

    // Decoded crd must be clean whenever a commit writes
    a_waddr_known: assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        wen_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

/* hw/cop_palu.sv */
// ====================
// Lane results wrap modulo the lane width. Shifts of a lane width or
// more give zero. Unused subclasses give zero
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_palu (
    input  wire logic [2:0]         op_i,     // Packed subclass
    input  wire logic [2:0]         pw_i,
    input  wire logic [3:0]         shamt_i,
    input  wire cop_pkg::cop_word_u a_i,
    input  wire cop_pkg::cop_word_u b_i,
    output cop_pkg::cop_word_u      y_o
);

    // One lane worth of work, lanes arrive zero-extended
    function automatic logic [31:0] lane_op(
        input logic [2:0]  op,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [3:0]  sh
    );
        case (op)
            cop_pkg::COP_SCLASS_PADD:   lane_op = a + b;
            cop_pkg::COP_SCLASS_PSUB:   lane_op = a - b;
            cop_pkg::COP_SCLASS_PSLL_I: lane_op = a << sh; // Caller truncates
            cop_pkg::COP_SCLASS_PSRL_I: lane_op = a >> sh;
            default:                    lane_op = '0;
        endcase
    endfunction

    always_comb begin
        y_o = '0;
        case (pw_i)
            cop_pkg::COP_PW_32: begin
                y_o.w = lane_op(op_i, a_i.w, b_i.w, shamt_i);
            end
            cop_pkg::COP_PW_16: begin
                for (int i = 0; i < 2; i++) begin
                    y_o.h[i] = 16'(lane_op(op_i, 32'(a_i.h[i]), 32'(b_i.h[i]), shamt_i));
                end
            end
            cop_pkg::COP_PW_8: begin
                for (int i = 0; i < 4; i++) begin
                    y_o.b[i] = 8'(lane_op(op_i, 32'(a_i.b[i]), 32'(b_i.b[i]), shamt_i));
                end
            end
            cop_pkg::COP_PW_4: begin
                for (int i = 0; i < 8; i++) begin
                    y_o.n[i] = 4'(lane_op(op_i, 32'(a_i.n[i]), 32'(b_i.n[i]), shamt_i));
                end
            end
            cop_pkg::COP_PW_2: begin
                for (int i = 0; i < 16; i++) begin
                    y_o.c[i] = 2'(lane_op(op_i, 32'(a_i.c[i]), 32'(b_i.c[i]), shamt_i));
                end
            end
            default: y_o = '0; // Decoder flags these widths anyway
        endcase
    end

endmodule

`default_nettype wire

/* hw/cop_ctrl.sv */
// ====================
// Four-phase req/ack. Ack rises 2 edges after req is seen and stays
// high with frozen outputs until req is sampled low
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_ctrl (
    input  wire logic        g_clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        cpu_req_i,
    input  wire logic [31:0] cpu_insn_i,
    input  wire logic [31:0] cpu_rs1_i,
    input  wire logic        exc_i,
    input  wire logic        gpr_wen_i,
    input  wire logic [4:0]  rd_i,
    input  wire logic [31:0] alu_i,
    input  wire logic [31:0] cpr_i,      // crs1 read
    input  wire logic [5:0]  mccr_i,
    input  wire logic [2:0]  sel_i,      // Decoded subclass
    output logic             cpu_ack_o,
    output logic             cpu_exc_o,
    output logic             cpu_rd_wen_o,
    output logic [4:0]       cpu_rd_o,
    output logic [31:0]      cpu_rd_data_o,
    output logic [31:0]      insn_o,
    output logic [31:0]      rs1_o,
    output logic             commit_o
);

    logic [1:0]  state_q;
    logic [31:0] result;

    // GPR result source
    always_comb begin
        case (sel_i)
            cop_pkg::COP_SCLASS_XCR2GPR: result = cpr_i;
            cop_pkg::COP_SCLASS_RMCCR:   result = {{(32-cop_pkg::COP_MCCR_W){1'b0}}, mccr_i};
            default:                     result = alu_i;
        endcase
    end

    assign commit_o = state_q == cop_pkg::COP_ST_EXEC; // One cycle only

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= cop_pkg::COP_ST_IDLE;
            insn_o       <= '0; // Zero decodes as illegal, no writes
            cpu_ack_o    <= 1'b0;
            cpu_exc_o    <= 1'b0;
            cpu_rd_wen_o <= 1'b0;
        end else begin
            case (state_q)
                cop_pkg::COP_ST_IDLE: if (cpu_req_i) begin
                    insn_o  <= cpu_insn_i;
                    state_q <= cop_pkg::COP_ST_EXEC;
                end
                cop_pkg::COP_ST_EXEC: begin
                    cpu_exc_o    <= exc_i;
                    cpu_rd_wen_o <= gpr_wen_i;
                    cpu_ack_o    <= 1'b1;
                    state_q      <= cop_pkg::COP_ST_ACK;
                end
                cop_pkg::COP_ST_ACK: if (!cpu_req_i) begin
                    cpu_ack_o <= 1'b0;
                    state_q   <= cop_pkg::COP_ST_IDLE;
                end
                default: state_q <= cop_pkg::COP_ST_IDLE;
            endcase
        end
    end

    // Operand and GPR payload
    always_ff @(posedge g_clk_i) begin
        if (state_q == cop_pkg::COP_ST_IDLE && cpu_req_i) begin
            rs1_o <= cpu_rs1_i;
        end
        if (commit_o) begin
            cpu_rd_o      <= rd_i;
            cpu_rd_data_o <= result;
        end
    end

    a_no_ack_without_req: assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        (!cpu_ack_o && !cpu_req_i) |=> !cpu_ack_o);

    a_stable_during_ack: assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        cpu_ack_o |=> !cpu_ack_o ||
            $stable({cpu_exc_o, cpu_rd_wen_o, cpu_rd_o, cpu_rd_data_o}));

endmodule

`default_nettype wire

/* hw/cop_top.sv */
// ====================
// One instruction in flight. The core must hold req until ack rises
// ====================
`timescale 1ns/1ps
`default_nettype none

module cop_top (
    input  wire logic        g_clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        cpu_req_i,
    input  wire logic [31:0] cpu_insn_i,
    input  wire logic [31:0] cpu_rs1_i,
    output logic             cpu_ack_o,
    output logic             cpu_exc_o,
    output logic             cpu_rd_wen_o,
    output logic [4:0]       cpu_rd_o,
    output logic [31:0]      cpu_rd_data_o
);

    logic [31:0]        insn;
    logic [31:0]        rs1;
    logic               commit;
    logic [5:0]         mccr;
    logic               id_exception;
    logic [3:0]         id_class;
    logic [2:0]         id_subclass;
    logic [2:0]         id_pw;
    logic [3:0]         id_crs1;
    logic [3:0]         id_crs2;
    logic [3:0]         id_crd;
    logic [4:0]         id_rd;
    logic [3:0]         id_shamt;
    logic               id_cpr_wen;
    logic               id_gpr_wen;
    logic               id_mccr_wen;
    cop_pkg::cop_word_u crs1_data;
    cop_pkg::cop_word_u crs2_data;
    cop_pkg::cop_word_u alu_y;
    cop_pkg::cop_word_u cpr_wdata;

    // GPR2XCR writes rs1, packed ops write the ALU result
    assign cpr_wdata.w = (id_class == cop_pkg::COP_ICLASS_MOVE) ? rs1 : alu_y.w;

    cop_ctrl i_ctrl (
        .g_clk_i, .arst_n_i, .cpu_req_i, .cpu_insn_i, .cpu_rs1_i,
        .exc_i(id_exception), .gpr_wen_i(id_gpr_wen), .rd_i(id_rd),
        .alu_i(alu_y.w), .cpr_i(crs1_data.w), .mccr_i(mccr), .sel_i(id_subclass),
        .cpu_ack_o, .cpu_exc_o, .cpu_rd_wen_o, .cpu_rd_o, .cpu_rd_data_o,
        .insn_o(insn), .rs1_o(rs1), .commit_o(commit)
    );

    cop_idecode i_idecode (
        .id_encoded_i(insn), .mccr_i(mccr),
        .id_exception_o(id_exception), .id_class_o(id_class),
        .id_subclass_o(id_subclass), .id_pw_o(id_pw),
        .id_crs1_o(id_crs1), .id_crs2_o(id_crs2), .id_crd_o(id_crd),
        .id_rd_o(id_rd), .id_shamt_o(id_shamt), .id_cpr_wen_o(id_cpr_wen),
        .id_gpr_wen_o(id_gpr_wen), .id_mccr_wen_o(id_mccr_wen)
    );

    cop_mccr i_mccr (
        .g_clk_i, .arst_n_i, .wen_i(id_mccr_wen && commit),
        .wdata_i(rs1[5:0]), .mccr_o(mccr)
    );

    cop_regfile i_regfile (
        .g_clk_i, .arst_n_i, .raddr1_i(id_crs1), .raddr2_i(id_crs2),
        .wen_i(id_cpr_wen && commit), .waddr_i(id_crd), .wdata_i(cpr_wdata),
        .rdata1_o(crs1_data), .rdata2_o(crs2_data)
    );

    cop_palu i_palu (
        .op_i(id_subclass), .pw_i(id_pw), .shamt_i(id_shamt),
        .a_i(crs1_data), .b_i(crs2_data), .y_o(alu_y)
    );

endmodule

`default_nettype wire

/* verif/tb_cop_top.sv */
// ====================
// Directed tests against a shadow CPR file and MCCR. Stops at the first mismatch
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_cop_top;

    localparam int TIMEOUT = 20; // Cycles allowed per handshake phase

    logic        g_clk_i;
    logic        arst_n_i;
    logic        cpu_req_i;
    logic [31:0] cpu_insn_i;
    logic [31:0] cpu_rs1_i;
    logic        cpu_ack_o;
    logic        cpu_exc_o;
    logic        cpu_rd_wen_o;
    logic [4:0]  cpu_rd_o;
    logic [31:0] cpu_rd_data_o;

    cop_pkg::cop_word_u cpr_model [16];
    logic [5:0]         mccr_model;
    integer             seed;
    logic               rsp_exc;      // Response captured while ack is high
    logic               rsp_wen;
    logic [4:0]         rsp_rd;
    cop_pkg::cop_word_u rsp_data;

    cop_top i_cop_top (.*);

    initial begin
        g_clk_i = 1'b0;
        forever #10 g_clk_i = ~g_clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cop_pkg::cop_word_u got,
                              input cop_pkg::cop_word_u exp);
        if (got.w !== exp.w) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
                                $time, name, got.w, exp.w));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s = %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s = %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // class | subclass | pw | crs2 | crs1 | unused | rd | opcode
    function automatic logic [31:0] encode(input logic [3:0] cls, input logic [2:0] sub,
                                           input logic [2:0] pw, input logic [3:0] crs2,
                                           input logic [3:0] crs1, input logic [4:0] rd);
        return {cls, sub, pw, crs2, crs1, 2'b00, rd, cop_pkg::COP_OPCODE};
    endfunction

    // Lane math by masking each lane out of the whole word
    function automatic cop_pkg::cop_word_u lane_model(input logic [2:0] op,
            input logic [2:0] pw, input cop_pkg::cop_word_u a,
            input cop_pkg::cop_word_u b, input logic [3:0] sh);
        int                 lw;
        logic [31:0]        mask;
        logic [31:0]        x;
        logic [31:0]        y;
        logic [31:0]        r;
        cop_pkg::cop_word_u res;
        lw    = 32 >> pw;
        mask  = (lw == 32) ? 32'hffff_ffff : (32'd1 << lw) - 32'd1;
        res.w = '0;
        for (int k = 0; k < 32; k += lw) begin
            x = (a.w >> k) & mask;
            y = (b.w >> k) & mask;
            case (op)
                cop_pkg::COP_SCLASS_PADD:   r = x + y;
                cop_pkg::COP_SCLASS_PSUB:   r = x - y;
                cop_pkg::COP_SCLASS_PSLL_I: r = (int'(sh) >= lw) ? 32'd0 : x << sh;
                cop_pkg::COP_SCLASS_PSRL_I: r = (int'(sh) >= lw) ? 32'd0 : x >> sh;
                default:                    r = 32'd0;
            endcase
            res.w = res.w | ((r & mask) << k);
        end
        return res;
    endfunction

    // Full four-phase exchange, response sampled mid-cycle
    task automatic issue_insn(input logic [31:0] insn, input logic [31:0] rs1);
        int cycles;
        @(posedge g_clk_i);
        cpu_req_i  <= 1'b1;
        cpu_insn_i <= insn;
        cpu_rs1_i  <= rs1;
        cycles = 0;
        @(negedge g_clk_i);
        while (!cpu_ack_o) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout waiting for the acknowledge to rise");
            @(negedge g_clk_i);
        end
        if (cycles != 2) abort_run("Acknowledge did not rise two edges after the request");
        rsp_exc    = cpu_exc_o;
        rsp_wen    = cpu_rd_wen_o;
        rsp_rd     = cpu_rd_o;
        rsp_data.w = cpu_rd_data_o;
        @(posedge g_clk_i);
        cpu_req_i <= 1'b0;
        cycles = 0;
        @(negedge g_clk_i);
        while (cpu_ack_o) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout waiting for the acknowledge to fall");
            @(negedge g_clk_i);
        end
    endtask

    task automatic write_cpr(input logic [3:0] idx, input logic [31:0] value);
        issue_insn(encode(cop_pkg::COP_ICLASS_MOVE, cop_pkg::COP_SCLASS_GPR2XCR, 3'd0,
                          4'd0, 4'd0, {idx, 1'b0}), value);
        check_flag("cpu_exc_o", rsp_exc, 1'b0);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b0);
        cpr_model[idx].w = value;
    endtask

    task automatic read_cpr(input logic [3:0] idx);
        logic [4:0] rd;
        rd = 5'($random(seed));
        issue_insn(encode(cop_pkg::COP_ICLASS_MOVE, cop_pkg::COP_SCLASS_XCR2GPR, 3'd0,
                          4'd0, idx, rd), 32'd0);
        check_flag("cpu_exc_o", rsp_exc, 1'b0);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b1);
        check_rd("cpu_rd_o", rsp_rd, rd);
        check_word("cpu_rd_data_o", rsp_data, cpr_model[idx]);
    endtask

    task automatic read_all_cprs();
        for (int i = 0; i < 16; i++) begin
            read_cpr(4'(i));
        end
    endtask

    // Exception expected from the current MCCR model
    task automatic run_packed(input logic [2:0] op, input logic [2:0] pw,
                              input logic [3:0] crs2, input logic [3:0] crs1,
                              input logic [3:0] crd);
        logic exp_exc;
        exp_exc = !mccr_model[cop_pkg::COP_MCCR_PA] || !mccr_model[int'(pw) + 1];
        issue_insn(encode(cop_pkg::COP_ICLASS_PACKED_ARITH, op, pw, crs2, crs1,
                          {crd, 1'b0}), 32'd0);
        check_flag("cpu_exc_o", rsp_exc, exp_exc);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b0);
        if (!exp_exc) begin
            cpr_model[crd] = lane_model(op, pw, cpr_model[crs1], cpr_model[crs2], crs2);
        end
        read_cpr(crd);
    endtask

    task automatic run_illegal(input logic [31:0] insn);
        issue_insn(insn, $random(seed));
        check_flag("cpu_exc_o", rsp_exc, 1'b1);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b0);
    endtask

    // Write MCCR with junk in the upper rs1 bits, then read it back
    task automatic set_mccr(input logic [5:0] value);
        cop_pkg::cop_word_u exp_word;
        issue_insn(encode(cop_pkg::COP_ICLASS_MOVE, cop_pkg::COP_SCLASS_WMCCR, 3'd0,
                          4'd0, 4'd0, 5'd0), {26'($random(seed)), value});
        check_flag("cpu_exc_o", rsp_exc, 1'b0);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b0);
        mccr_model = value;
        exp_word.w = {26'd0, value};
        issue_insn(encode(cop_pkg::COP_ICLASS_MOVE, cop_pkg::COP_SCLASS_RMCCR, 3'd0,
                          4'd0, 4'd0, 5'd9), 32'd0);
        check_flag("cpu_rd_wen_o", rsp_wen, 1'b1);
        check_rd("cpu_rd_o", rsp_rd, 5'd9);
        check_word("cpu_rd_data_o", rsp_data, exp_word);
    endtask

    task automatic test_reset();
        @(negedge g_clk_i);
        check_flag("cpu_ack_o", cpu_ack_o, 1'b0);
        check_flag("cpu_exc_o", cpu_exc_o, 1'b0);
        check_flag("cpu_rd_wen_o", cpu_rd_wen_o, 1'b0);
        read_all_cprs();
    endtask

    task automatic test_moves();
        for (int i = 0; i < 16; i++) begin
            write_cpr(4'(i), $random(seed));
        end
        read_all_cprs();
    endtask

    task automatic test_add_sub();
        logic [3:0] ra;
        logic [3:0] rb;
        for (int p = 0; p < 5; p++) begin
            for (int n = 0; n < 4; n++) begin
                ra = 4'($random(seed));
                rb = 4'($random(seed));
                write_cpr(ra, $random(seed));
                write_cpr(rb, $random(seed));
                run_packed((n < 2) ? cop_pkg::COP_SCLASS_PADD : cop_pkg::COP_SCLASS_PSUB,
                           3'(p), rb, ra, 4'($random(seed)));
            end
        end
    endtask

    task automatic test_shifts();
        for (int p = 0; p < 5; p++) begin
            for (int s = 0; s < 16; s++) begin
                write_cpr(4'd4, $random(seed));
                run_packed(cop_pkg::COP_SCLASS_PSLL_I, 3'(p), 4'(s), 4'd4, 4'd5);
                run_packed(cop_pkg::COP_SCLASS_PSRL_I, 3'(p), 4'(s), 4'd4, 4'd6);
            end
        end
    endtask

    task automatic test_illegal();
        write_cpr(4'd6, $random(seed));
        // Custom-1 opcode instead of custom-0
        run_illegal(encode(cop_pkg::COP_ICLASS_MOVE, cop_pkg::COP_SCLASS_GPR2XCR, 3'd0,
                           4'd0, 4'd0, 5'd12) ^ 32'h0000_0020);
        run_illegal(encode(4'h2, 3'd0, 3'd0, 4'd1, 4'd2, 5'd12));
        run_illegal(encode(cop_pkg::COP_ICLASS_PACKED_ARITH, 3'd4, 3'd0, 4'd1, 4'd2, 5'd12));
        run_illegal(encode(cop_pkg::COP_ICLASS_MOVE, 3'd7, 3'd0, 4'd1, 4'd2, 5'd12));
        for (int p = 5; p < 8; p++) begin
            run_illegal(encode(cop_pkg::COP_ICLASS_PACKED_ARITH, cop_pkg::COP_SCLASS_PADD,
                               3'(p), 4'd1, 4'd2, 5'd12));
        end
        read_all_cprs();
    endtask

    task automatic test_mccr();
        set_mccr(6'b111110);              // Packed arithmetic off
        for (int p = 0; p < 5; p++) begin
            run_packed(cop_pkg::COP_SCLASS_PADD, 3'(p), 4'd1, 4'd2, 4'd7);
        end
        set_mccr(6'b110111);              // Only 8-bit lanes off
        for (int p = 0; p < 5; p++) begin
            run_packed(cop_pkg::COP_SCLASS_PSUB, 3'(p), 4'd1, 4'd2, 4'd7);
        end
        set_mccr(6'b111111);
        run_packed(cop_pkg::COP_SCLASS_PSUB, cop_pkg::COP_PW_8, 4'd1, 4'd2, 4'd7);
    endtask

    initial begin
        seed       = 32'h5f0c01ae;
        arst_n_i   = 1'b0;
        cpu_req_i  = 1'b0;
        cpu_insn_i = 32'd0;
        cpu_rs1_i  = 32'd0;
        mccr_model = cop_pkg::COP_MCCR_RESET;
        for (int i = 0; i < 16; i++) begin
            cpr_model[i].w = 32'd0;
        end
        repeat (2) @(posedge g_clk_i);
        arst_n_i <= 1'b1;
        test_reset();
        test_moves();
        test_add_sub();
        test_shifts();
        test_illegal();
        test_mccr();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/cop_pkg.sv
hw/cop_idecode.sv
hw/cop_mccr.sv
hw/cop_regfile.sv
hw/cop_palu.sv
hw/cop_ctrl.sv
hw/cop_top.sv
verif/tb_cop_top.sv

/* Makefile */
# Verilator flow for the coprocessor testbench
VERILATOR ?= verilator
TOP       ?= tb_cop_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
